/* logic/cpuBusPkg.sv */
// CPU bus transfer descriptors: SIZ codes, TT transfer types and line burst length
package cpuBusPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Transfer size, encoded as on the SIZ1:SIZ0 pins
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        sizeLong = 2'd0,    // 4 bytes
        sizeByte = 2'd1,    // 1 byte
        sizeWord = 2'd2,    // 2 bytes
        sizeLine = 2'd3     // 16 bytes, line
    } cpuSize;

    ////////////////////////////////////////////////////////////////////////////
    // Transfer type, as on the TT1:TT0 pins
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        ttNormal    = 2'd0,
        ttMove16    = 2'd1,  // Line burst request
        ttAltAccess = 2'd2,
        ttAck       = 2'd3   // Interrupt ack and friends
    } transferType;

    // Long words in one cache line
    localparam int burstBeats = 4;
    localparam int beatCountW = $clog2(burstBeats) + 1;  // Must hold burstBeats itself

endpackage

/* logic/dynSizePkg.sv */
// Dynamic bus sizing state encoding and DSACK acknowledge codes
package dynSizePkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizing states, one per target access shape
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        stIdle   = 4'd0,
        stLongA  = 4'd1,    // Long or line, first access
        stLongB  = 4'd2,    // Second half of a long on a 16-bit port
        stWordA0 = 4'd3,
        stWordA2 = 4'd4,
        stByteA0 = 4'd5,
        stByteA1 = 4'd6,
        stByteA2 = 4'd7,
        stByteA3 = 4'd8
    } sizerState;

    ////////////////////////////////////////////////////////////////////////////
    // Port acknowledge, active low like DSACK1:DSACK0
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        ackLong = 2'b00,    // 32-bit port
        ackWord = 2'b01,    // 16-bit port
        ackByte = 2'b10,    // 8-bit port, not supported here
        ackNone = 2'b11     // No acknowledge, wait
    } portAck;

endpackage

/* logic/sizingSequencer.sv */
// Dynamic bus sizing FSM with line burst counter and falling edge termination outputs
module sizingSequencer
    import cpuBusPkg::*;
    import dynSizePkg::*;
(
    input  logic        BCLK,
    input  logic        nRESET,
    input  logic [1:0]  a,
    input  cpuSize      siz,
    input  transferType tt,
    input  logic        nTsCpu,
    input  portAck      dsack,
    input  logic        nTbi,
    input  logic        nTci,
    output logic        nTs,
    output logic        nTa,
    output logic        nTbiCpu,
    output logic        nTciCpu,
    output logic [1:0]  targetA,
    output sizerState   state
);

    logic                  tsReq;        // Start strobe request, rising edge domain
    logic                  taReq;        // Transfer ack request
    logic                  tbiReq;       // Burst inhibit to CPU
    logic                  tciReq;       // Cache inhibit to CPU
    logic                  burstReq;     // MOVE16 line burst in progress
    logic                  inhibitSeen;  // Target refused the burst
    logic [beatCountW-1:0] beatCount;    // Long words done in this line
    logic [1:0]            aReg;         // Address held for the whole transfer
    sizerState             firstState;

    ////////////////////////////////////////////////////////////////////////////
    // First sizing state from SIZ and A1:A0
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (siz)
            sizeWord: firstState = a[1] ? stWordA2 : stWordA0;  // A0 ignored
            sizeByte: begin
                case (a)
                    2'd0:    firstState = stByteA0;
                    2'd1:    firstState = stByteA1;
                    2'd2:    firstState = stByteA2;
                    default: firstState = stByteA3;
                endcase
            end
            default: firstState = stLongA;   // Long word and line
        endcase
    end

    // Second half of a split long always goes to offset 2
    assign targetA = (state == stLongB) ? 2'd2 : aReg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizing FSM, sampled on rising BCLK
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            state       <= stIdle;
            tsReq       <= 1'b0;
            taReq       <= 1'b0;
            tbiReq      <= 1'b0;
            tciReq      <= 1'b0;
            burstReq    <= 1'b0;
            inhibitSeen <= 1'b0;
            beatCount   <= '0;
            aReg        <= 2'd0;
        end else begin
            tsReq <= 1'b0;                          // Strobe is one cycle only
            case (state)
                stIdle: begin
                    taReq  <= 1'b0;
                    tbiReq <= 1'b0;
                    tciReq <= 1'b0;
                    if (!nTsCpu) begin              // CPU starts a transfer
                        tsReq       <= 1'b1;
                        state       <= firstState;
                        aReg        <= a;
                        burstReq    <= (tt == ttMove16);
                        inhibitSeen <= 1'b0;
                        beatCount   <= '0;
                    end
                end

                stLongA: begin
                    if (dsack == ackLong) begin     // Full long word, one beat
                        taReq       <= 1'b1;
                        tbiReq      <= ~nTbi;
                        tciReq      <= ~nTci;
                        inhibitSeen <= inhibitSeen | ~nTbi;
                        beatCount   <= beatCount + 1'b1;
                    end else if (dsack == ackWord) begin
                        tsReq <= 1'b1;              // Restrobe for the low word
                        state <= stLongB;           // No TA for the first half
                    end else if (taReq) begin       // DSACK released, end the beat
                        taReq  <= 1'b0;
                        tbiReq <= 1'b0;
                        tciReq <= 1'b0;
                        if (!burstReq || inhibitSeen ||
                            beatCount == beatCountW'(burstBeats)) begin
                            state <= stIdle;
                        end
                    end
                end

                default: begin                      // stLongB, words and bytes
                    if (dsack != ackNone) begin
                        taReq  <= 1'b1;
                        tbiReq <= ~nTbi;
                        tciReq <= ~nTci;
                    end else if (taReq) begin
                        taReq  <= 1'b0;
                        tbiReq <= 1'b0;
                        tciReq <= 1'b0;
                        state  <= stIdle;
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Termination pins change half a cycle later, on falling BCLK
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(negedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            nTs     <= 1'b1;
            nTa     <= 1'b1;
            nTbiCpu <= 1'b1;
            nTciCpu <= 1'b1;
        end else begin
            nTs     <= ~tsReq;
            nTa     <= ~taReq;
            nTbiCpu <= ~tbiReq;
            nTciCpu <= ~tciReq;
        end
    end

    // Byte ports are not terminated by this bridge
    assert property (@(posedge BCLK) disable iff (!nRESET)
        (state != stIdle) |-> (dsack != ackByte));

    // Falling edge TA must be released before the FSM is seen idle
    assert property (@(posedge BCLK) disable iff (!nRESET)
        (state == stIdle) |-> nTa);

endmodule

/* logic/readLaneLatch.sv */
// Read data lane steering and latch from target lanes into CPU lanes
module readLaneLatch
    import dynSizePkg::*;
(
    input  logic        BCLK,
    input  logic        nRESET,
    input  sizerState   state,
    input  portAck      dsack,
    input  logic [31:0] portReadData,
    output logic [31:0] cpuReadData
);

    logic [0:3][7:0] inLane;    // Lane 0 is bits 31:24
    logic [0:3][7:0] rdLane;    // Latched CPU lanes

    assign inLane      = portReadData;
    assign cpuReadData = rdLane;

    ////////////////////////////////////////////////////////////////////////////
    // Latch on every acknowledging rising edge, lanes hold otherwise
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            rdLane <= '0;
        end else if (dsack != ackNone) begin
            case (state)
                stLongA: begin
                    if (dsack == ackLong) begin
                        rdLane <= inLane;               // 32-bit port, whole long
                    end else begin
                        rdLane[0] <= inLane[0];         // 16-bit port, high word
                        rdLane[1] <= inLane[1];
                    end
                end
                stLongB: begin
                    rdLane[2] <= inLane[0];             // Low word arrives on lanes 0,1
                    rdLane[3] <= inLane[1];
                end
                stWordA2: begin
                    rdLane[0] <= inLane[2];             // Copy word down
                    rdLane[1] <= inLane[3];
                    rdLane[2] <= inLane[2];
                    rdLane[3] <= inLane[3];
                end
                stByteA1: begin
                    rdLane[0] <= inLane[1];
                    rdLane[1] <= inLane[1];
                    rdLane[2] <= inLane[2];
                    rdLane[3] <= inLane[3];
                end
                stByteA2: begin
                    rdLane[0] <= inLane[2];
                    rdLane[1] <= inLane[1];
                    rdLane[2] <= inLane[2];
                    rdLane[3] <= inLane[3];
                end
                stByteA3: begin
                    rdLane[0] <= inLane[3];
                    rdLane[1] <= inLane[1];
                    rdLane[2] <= inLane[2];
                    rdLane[3] <= inLane[3];
                end
                stWordA0, stByteA0: begin
                    rdLane <= inLane;                   // Already in place
                end
                default: begin
                    rdLane <= rdLane;                   // Idle, keep last value
                end
            endcase
        end
    end

endmodule

/* logic/writeLaneSteer.sv */
// Write data lane steering from CPU lanes onto target lanes per sizing state
module writeLaneSteer
    import dynSizePkg::*;
(
    input  sizerState   state,
    input  logic [31:0] cpuWriteData,
    output logic [31:0] portWriteData
);

    logic [0:3][7:0] cpuLane;   // Lane 0 is bits 31:24
    logic [0:3][7:0] outLane;

    assign cpuLane       = cpuWriteData;
    assign portWriteData = outLane;

    // Target picks its bytes from SIZ and A, so extra lanes are don't care
    always_comb begin
        case (state)
            stLongA, stWordA0, stByteA0: begin
                outLane = cpuLane;                          // Straight through
            end
            stLongB, stWordA2: begin
                outLane = {cpuLane[2], cpuLane[3], cpuLane[2], cpuLane[3]};
            end
            stByteA1: begin
                outLane = {cpuLane[1], cpuLane[1], cpuLane[2], cpuLane[3]};
            end
            stByteA2: begin
                outLane = {cpuLane[2], cpuLane[1], cpuLane[2], cpuLane[3]};
            end
            stByteA3: begin
                outLane = {4{cpuLane[3]}};                  // Reaches any port width
            end
            default: begin
                outLane = '0;                               // Idle
            end
        endcase
    end

endmodule

/* logic/busSizerTop.sv */
// Bus sizing bridge top: sequencer, read lane latch and write lane steering
module busSizerTop
    import cpuBusPkg::*;
    import dynSizePkg::*;
(
    input  logic        BCLK,
    input  logic        nRESET,
    // CPU side
    input  logic [1:0]  a,
    input  cpuSize      siz,
    input  transferType tt,
    input  logic        rnw,
    input  logic        nTsCpu,
    input  logic [31:0] cpuWriteData,
    output logic        nTa,
    output logic        nTbiCpu,
    output logic        nTciCpu,
    output logic [31:0] cpuReadData,
    // Target side
    output logic        nTs,
    output logic [1:0]  targetA,
    output logic [31:0] portWriteData,
    input  portAck      dsack,
    input  logic        nTbi,
    input  logic        nTci,
    input  logic [31:0] portReadData
);

    sizerState state;   // Shared sizing state

    sizingSequencer sequencer (
        .BCLK    (BCLK),
        .nRESET  (nRESET),
        .a       (a),
        .siz     (siz),
        .tt      (tt),
        .nTsCpu  (nTsCpu),
        .dsack   (dsack),
        .nTbi    (nTbi),
        .nTci    (nTci),
        .nTs     (nTs),
        .nTa     (nTa),
        .nTbiCpu (nTbiCpu),
        .nTciCpu (nTciCpu),
        .targetA (targetA),
        .state   (state)
    );

    readLaneLatch readLanes (
        .BCLK         (BCLK),
        .nRESET       (nRESET),
        .state        (state),
        .dsack        (dsack),
        .portReadData (portReadData),
        .cpuReadData  (cpuReadData)
    );

    writeLaneSteer writeLanes (
        .state         (state),
        .cpuWriteData  (cpuWriteData),
        .portWriteData (portWriteData)
    );

    // Direction must hold for every access of a sized transfer
    assert property (@(posedge BCLK) disable iff (!nRESET)
        (state != stIdle) |-> $stable(rnw));

endmodule

/* testbench/sizedPortModel.sv */
// Target port model: 32 or 16 bit width, byte memory, random wait states, DSACK, TBI and TCI
module sizedPortModel
    import cpuBusPkg::*;
    import dynSizePkg::*;
(
    input  logic        BCLK,
    input  logic        nTs,
    input  logic [1:0]  targetA,
    input  logic        rnw,
    input  cpuSize      siz,
    input  logic        portWide,       // 1 for a 32-bit port, 0 for 16-bit
    input  logic        inhibitBurst,   // Refuse line bursts
    input  logic        inhibitCache,
    input  logic [31:0] portWriteData,
    output portAck      dsack,
    output logic        nTbi,
    output logic        nTci,
    output logic [31:0] portReadData
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] mem [0:15];     // Four long words, byte 0 is the MSB of a word
    integer     seed = 20315;

    // 16-bit port answers on lanes 0,1 and mirrors them on lanes 2,3
    function automatic logic [31:0] readBeat(input int b, input logic [1:0] addr);
        int h;
        h = addr & 2;
        if (portWide) begin
            return {mem[b*4], mem[b*4+1], mem[b*4+2], mem[b*4+3]};
        end else begin
            return {mem[h], mem[h+1], mem[h], mem[h+1]};
        end
    endfunction

    task automatic storeBeat(input int b, input logic [1:0] addr);
        int first;
        int count;
        if (portWide && (siz == sizeLong || siz == sizeLine)) begin
            first = 0;
            count = 4;
        end else if (siz == sizeByte) begin
            first = addr;
            count = 1;
        end else begin
            first = addr & 2;   // Word, or half a long on a 16-bit port
            count = 2;
        end
        for (int k = first; k < first + count; k++) begin
            mem[b*4+k] = portWriteData[31 - 8*(portWide ? k : k % 2) -: 8];
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One access per nTs strobe, four beats for an accepted line burst
    ////////////////////////////////////////////////////////////////////////////

    task automatic serveAccess();
        logic [1:0] addr;
        int         beats;
        int         waits;
        addr  = targetA;
        beats = (portWide && siz == sizeLine && !inhibitBurst) ? burstBeats : 1;
        for (int b = 0; b < beats; b++) begin
            waits = $unsigned($random(seed)) % 3;
            if (b > 0) waits = waits + 1;       // DSACK must be seen released between beats
            repeat (waits) begin
                @(posedge BCLK);
                #1;
            end
            if (rnw) portReadData = readBeat(b, addr);
            else     storeBeat(b, addr);
            dsack = portWide ? ackLong : ackWord;
            nTbi  = !(inhibitBurst && b == 0);
            nTci  = !inhibitCache;
            @(posedge BCLK);
            #1;
            dsack = ackNone;                    // Acknowledge lasts one cycle
            nTbi  = 1'b1;
            nTci  = 1'b1;
        end
    endtask

    initial begin
        dsack        = ackNone;
        nTbi         = 1'b1;
        nTci         = 1'b1;
        portReadData = '0;
        for (int i = 0; i < 16; i++) begin
            mem[i] = 8'(i * 59) ^ 8'hc6;        // Distinct byte per address
        end
        forever begin
            @(posedge BCLK);
            #1;
            if (nTs === 1'b0) serveAccess();
        end
    end

endmodule

/* testbench/busSizerTb.sv */
// Testbench top: clock, reset, compare task and directed tests of the bus sizing bridge
module busSizerTb
    import cpuBusPkg::*;
    import dynSizePkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic        BCLK;
    logic        nRESET;
    logic [1:0]  a;
    cpuSize      siz;
    transferType tt;
    logic        rnw;
    logic        nTsCpu;
    logic [31:0] cpuWriteData;
    logic        nTa;
    logic        nTbiCpu;
    logic        nTciCpu;
    logic [31:0] cpuReadData;
    logic        nTs;
    logic [1:0]  targetA;
    logic [31:0] portWriteData;
    portAck      dsack;
    logic        nTbi;
    logic        nTci;
    logic [31:0] portReadData;
    logic        portWide;          // Model width
    logic        inhibitBurst;
    logic        inhibitCache;
    logic [7:0]  refMem [0:15];     // Expected target memory
    logic [1:0]  strobeA [$];       // targetA at each nTs strobe
    integer      seed;

    busSizerTop UUT (.*);
    sizedPortModel portModel (.*);

    initial BCLK = 1'b0;
    always #4 BCLK = ~BCLK;         // 8 ns period

    // Log every start strobe the bridge gives the target
    always begin
        @(posedge BCLK);
        #1;
        if (nRESET === 1'b1 && nTs === 1'b0) strobeA.push_back(targetA);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting, compare and wait helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic expectEqual(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) stopRun($sformatf("mismatch %s: got %h expected %h", name, got, want));
    endtask

    task automatic waitTa(input logic level);
        int n;
        n = 0;
        while (nTa !== level) begin
            @(posedge BCLK);
            #1;
            n++;
            if (n > 64) stopRun($sformatf("timed out waiting for nTa to go %0b", level));
        end
    endtask

    function automatic logic [31:0] refWord(input int beat);
        return {refMem[beat*4], refMem[beat*4+1], refMem[beat*4+2], refMem[beat*4+3]};
    endfunction

    task automatic loadReference();
        for (int i = 0; i < 16; i++) refMem[i] = portModel.mem[i];
    endtask

    // One cycle CPU strobe, driven 1 ns after the rising edge
    task automatic startTransfer(input cpuSize s, input logic [1:0] addr, input logic readNotWrite,
                                 input transferType t, input logic [31:0] wdata);
        strobeA.delete();
        siz          = s;
        a            = addr;
        tt           = t;
        rnw          = readNotWrite;
        cpuWriteData = wdata;
        nTsCpu       = 1'b0;
        @(posedge BCLK);
        #1;
        nTsCpu = 1'b1;
    endtask

    task automatic transact(input cpuSize s, input logic [1:0] addr, input logic readNotWrite,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic tbi, output logic tci);
        startTransfer(s, addr, readNotWrite, ttNormal, wdata);
        waitTa(1'b0);
        rdata = cpuReadData;            // Valid while nTa is low
        tbi   = nTbiCpu;
        tci   = nTciCpu;
        waitTa(1'b1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic resetValues();
        expectEqual("nTs", 32'(nTs), 1);
        expectEqual("nTa", 32'(nTa), 1);
        expectEqual("nTbiCpu", 32'(nTbiCpu), 1);
        expectEqual("nTciCpu", 32'(nTciCpu), 1);
        expectEqual("cpuReadData", cpuReadData, 0);
    endtask

    task automatic longReads();
        logic [31:0] rdata;
        logic        tbi;
        logic        tci;
        for (int w = 0; w < 2; w++) begin
            portWide = (w == 1);            // 16-bit port first, CPU lanes still hold reset zero
            loadReference();
            transact(sizeLong, 2'd0, 1'b1, 32'd0, rdata, tbi, tci);
            expectEqual("cpuReadData", rdata, refWord(0));
            expectEqual("nTs strobe count", strobeA.size(), portWide ? 1 : 2);
            expectEqual("targetA", 32'(strobeA[0]), 0);
            if (!portWide) expectEqual("targetA", 32'(strobeA[1]), 2);  // Low word restrobe
        end
    endtask

    task automatic narrowReads();
        logic [0:3][7:0] lanes;
        logic [31:0]     rdata;
        logic            tbi;
        logic            tci;
        cpuSize          s;
        logic [1:0]      addr;
        portWide = 1'b1;
        loadReference();
        for (int k = 0; k < 6; k++) begin
            s    = (k < 2) ? sizeWord : sizeByte;
            addr = (k < 2) ? 2'(k * 2) : 2'(k - 2);
            transact(s, addr, 1'b1, 32'd0, rdata, tbi, tci);
            lanes = refWord(0);
            lanes[0] = lanes[addr];                 // Addressed data lands in lane 0
            if (s == sizeWord) lanes[1] = lanes[addr + 1];
            expectEqual("cpuReadData", rdata, lanes);
        end
    endtask

    task automatic sizedWrites();
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic        tbi;
        logic        tci;
        cpuSize      s;
        logic [1:0]  addr;
        for (int w = 0; w < 2; w++) begin
            portWide = (w == 0);
            for (int k = 0; k < 7; k++) begin
                s     = (k == 0) ? sizeLong : (k < 3) ? sizeWord : sizeByte;
                addr  = (k == 0) ? 2'd0 : (k < 3) ? 2'((k - 1) * 2) : 2'(k - 3);
                wdata = $random(seed);
                loadReference();
                transact(s, addr, 1'b0, wdata, rdata, tbi, tci);
                for (int b = 0; b < 4; b++) begin
                    if (s == sizeLong || (s == sizeWord && b[1] == addr[1]) ||
                        (s == sizeByte && b == addr)) begin
                        refMem[b] = wdata[31 - 8*b -: 8];   // CPU lane b is byte b
                    end
                end
                for (int i = 0; i < 16; i++) begin
                    expectEqual($sformatf("mem[%0d]", i), 32'(portModel.mem[i]), 32'(refMem[i]));
                end
            end
        end
    endtask

    task automatic lineBursts();
        logic [31:0] rdata;
        logic        tbi;
        logic        tci;
        portWide = 1'b1;
        loadReference();
        startTransfer(sizeLine, 2'd0, 1'b1, ttMove16, 32'd0);
        for (int b = 0; b < burstBeats; b++) begin
            waitTa(1'b0);
            expectEqual("cpuReadData", cpuReadData, refWord(b));
            expectEqual("nTbiCpu", 32'(nTbiCpu), 1);
            waitTa(1'b1);
        end
        expectEqual("nTs strobe count", strobeA.size(), 1);
        inhibitBurst = 1'b1;                        // Target refuses the line
        startTransfer(sizeLine, 2'd0, 1'b1, ttMove16, 32'd0);
        waitTa(1'b0);
        expectEqual("cpuReadData", cpuReadData, refWord(0));
        expectEqual("nTbiCpu", 32'(nTbiCpu), 0);
        waitTa(1'b1);
        inhibitBurst = 1'b0;
        transact(sizeLong, 2'd0, 1'b1, 32'd0, rdata, tbi, tci);
        expectEqual("cpuReadData", rdata, refWord(0));
        expectEqual("nTbiCpu", 32'(tbi), 1);
    endtask

    task automatic cacheInhibit();
        logic [31:0] rdata;
        logic        tbi;
        logic        tci;
        portWide     = 1'b1;
        inhibitCache = 1'b1;
        transact(sizeLong, 2'd0, 1'b1, 32'd0, rdata, tbi, tci);
        expectEqual("nTciCpu", 32'(tci), 0);
        inhibitCache = 1'b0;
        transact(sizeLong, 2'd0, 1'b1, 32'd0, rdata, tbi, tci);
        expectEqual("nTciCpu", 32'(tci), 1);
    endtask

    initial begin
        seed         = 20315;
        nRESET       = 1'b0;
        a            = 2'd0;
        siz          = sizeLong;
        tt           = ttNormal;
        rnw          = 1'b1;
        nTsCpu       = 1'b1;
        cpuWriteData = '0;
        portWide     = 1'b1;
        inhibitBurst = 1'b0;
        inhibitCache = 1'b0;
        repeat (3) @(posedge BCLK);
        #1;
        nRESET = 1'b1;
        resetValues();
        longReads();
        narrowReads();
        sizedWrites();
        lineBursts();
        cacheInhibit();
        $display("Regression passed");
        $finish;
    end

endmodule

/* compile.f */
logic/cpuBusPkg.sv
logic/dynSizePkg.sv
logic/sizingSequencer.sv
logic/readLaneLatch.sv
logic/writeLaneSteer.sv
logic/busSizerTop.sv
testbench/sizedPortModel.sv
testbench/busSizerTb.sv

/* Makefile */
# Verilator build, run, lint and clean for the bus sizing bridge testbench
TOP := busSizerTb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f $(wildcard logic/*.sv testbench/*.sv)
	verilator --binary --timing --assert -j 0 -f compile.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir
